/* src/router_config.svh */
`ifndef ROUTER_CONFIG_SVH
`define ROUTER_CONFIG_SVH

// one flit carries a 3-bit id and 13 bits of header or body payload.
`define FLIT_WIDTH 16

// local, north, east, west and south.
`define NUM_PORTS 5

// entries in each input queue.
`define QUEUE_DEPTH 8

// body count carried in the header flit.
`define LENGTH_WIDTH 12

`endif

/* src/routerPkg.sv */
`include "router_config.svh"

package routerPkg;

  localparam logic [2:0] headFlitId = 3'b001;
  localparam logic [2:0] bodyFlitId = 3'b010;

  typedef struct packed
  {
    logic [2:0]               flitId;
    logic                     spare;
    logic [`LENGTH_WIDTH-1:0] length; // number of body flits that follow.
  } headerFields;

  typedef struct packed
  {
    logic [2:0]             flitId;
    logic [`FLIT_WIDTH-4:0] data;
  } bodyFields;

  // The same word is read as a header or as a body depending on its id.
  typedef union packed
  {
    headerFields headerView;
    bodyFields   bodyView;
  } flitWord;

  // bit 0 is local, bit 4 is south.
  typedef logic [`NUM_PORTS-1:0] portMask;

endpackage

/* src/flitQueue.sv */
`timescale 1ns/1ps
`include "router_config.svh"

module flitQueue
  import routerPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    pushValid,
  input  flitWord pushFlit,
  output logic    full,
  input  logic    pop,
  output flitWord headFlit,
  output logic    notEmpty
);

  localparam int AddrWidth = $clog2(`QUEUE_DEPTH);

  flitWord mem [`QUEUE_DEPTH];
  logic [AddrWidth-1:0] rdPtr;
  logic [AddrWidth-1:0] wrPtr;
  logic [AddrWidth:0] count;
  logic doPush;
  logic doPop;

  assign doPush = pushValid && !full; // a push into a full queue is dropped.
  assign doPop = pop && notEmpty;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
        wrPtr <= wrPtr + 1'b1; // depth is a power of two, so the pointer wraps by itself.
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
      count <= count + (AddrWidth + 1)'(doPush) - (AddrWidth + 1)'(doPop);
    end
  end

  always_ff @(posedge clk)
  begin
    if (doPush)
      mem[wrPtr] <= pushFlit;
  end

  assign headFlit = mem[rdPtr];
  assign full = (count == (AddrWidth + 1)'(`QUEUE_DEPTH));
  assign notEmpty = (count != '0);

  // The source watches full and must hold its push off.
  noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
    !(pushValid && full))
    else $error("flitQueue: push while full at %0t", $time);

  // The arbiter only pops a queue it has seen holding a flit.
  noPopWhenEmpty: assert property (@(posedge clk) disable iff (rst)
    !(pop && !notEmpty))
    else $error("flitQueue: pop while empty at %0t", $time);

endmodule

/* src/packetTimer.sv */
`timescale 1ns/1ps
`include "router_config.svh"

module packetTimer
  import routerPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    pop,
  input  flitWord headFlit,
  output logic    lastFlit
);

  logic [`LENGTH_WIDTH-1:0] length;
  logic [`LENGTH_WIDTH-1:0] count;
  logic isHeader;

  assign isHeader = (headFlit.headerView.flitId == headFlitId);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      length <= '0;
      count <= '0;
    end
    else if (pop && isHeader)
    begin
      length <= headFlit.headerView.length;
      count <= '0;
    end
    else if (pop)
      count <= count + 1'b1; // bodies forwarded so far.
  end

  always_comb
  begin
    if (!pop)
      lastFlit = 1'b0;
    else if (isHeader)
      lastFlit = (headFlit.headerView.length == '0); // header-only packet.
    else
      lastFlit = ((count + 1'b1) == length);
  end

endmodule

/* src/outputArbiter.sv */
`timescale 1ns/1ps
`include "router_config.svh"

module outputArbiter
  import routerPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  flitWord headFlit [`NUM_PORTS],
  input  portMask notEmpty,
  output portMask pop,
  output flitWord outFlit,
  output logic    outValid,
  output portMask outPort
);

  portMask grant; // all zero while idle.
  portMask nextGrant;
  portMask lastServed;
  portMask lastVec;
  logic grantDone;
  flitWord selFlit;

  // First requester after the one-hot position in after, going L, N, E, W, S.
  // The port in after itself comes last.
  function automatic portMask pickNext(portMask after, portMask req);
    portMask pick;
    int base;
    int idx;
    pick = '0;
    base = 0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (after[i])
        base = i;
    end
    for (int k = `NUM_PORTS; k >= 1; k--)
    begin
      idx = (base + k) % `NUM_PORTS;
      if (req[idx])
      begin
        pick = '0;
        pick[idx] = 1'b1; // later hits are closer to base, so they win.
      end
    end
    return pick;
  endfunction

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : genTimer
    packetTimer timer_i (
      .clk      (clk),
      .rst      (rst),
      .pop      (pop[p]),
      .headFlit (headFlit[p]),
      .lastFlit (lastVec[p])
    );
  end

  // The granted port is drained whenever it has a flit, and waits otherwise.
  assign pop = grant & notEmpty;
  assign grantDone = |(pop & lastVec);

  always_comb
  begin
    nextGrant = grant;
    if (grant == '0)
      nextGrant = pickNext(lastServed, notEmpty);
    else if (grantDone)
      nextGrant = pickNext(grant, notEmpty & ~grant); // handover without a bubble.
  end

  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (pop[i])
        selFlit = headFlit[i];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= '0;
      lastServed <= portMask'(1) << (`NUM_PORTS - 1); // south, so local goes first.
      outValid <= 1'b0;
      outPort <= '0;
    end
    else
    begin
      grant <= nextGrant;
      if (grantDone)
        lastServed <= grant;
      outValid <= |pop;
      outPort <= pop;
    end
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
      outFlit <= selFlit;
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant))
    else $error("outputArbiter: grant %b is not one-hot at %0t", grant, $time);

  // Once a packet has started, every later pop under the same grant is a body flit.
  bodyInsidePacket: assert property (@(posedge clk) disable iff (rst)
    (pop != '0 && grant == $past(grant)) |->
      (selFlit.bodyView.flitId == bodyFlitId))
    else $error("outputArbiter: pop %b took a non-body flit inside a packet at %0t",
                pop, $time);

  // A fresh grant always lands on a port whose queue head starts a packet.
  firstPopIsHeader: assert property (@(posedge clk) disable iff (rst)
    (grant != '0 && grant != $past(grant)) |->
      (pop == grant && selFlit.headerView.flitId == headFlitId))
    else $error("outputArbiter: grant %b started on a body flit at %0t", grant, $time);

endmodule

/* src/routerOutputPort.sv */
`timescale 1ns/1ps
`include "router_config.svh"

module routerOutputPort
  import routerPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`FLIT_WIDTH-1:0] lFlit,
  input  logic [`FLIT_WIDTH-1:0] nFlit,
  input  logic [`FLIT_WIDTH-1:0] eFlit,
  input  logic [`FLIT_WIDTH-1:0] wFlit,
  input  logic [`FLIT_WIDTH-1:0] sFlit,
  input  logic                   lValid,
  input  logic                   nValid,
  input  logic                   eValid,
  input  logic                   wValid,
  input  logic                   sValid,
  output logic                   lFull,
  output logic                   nFull,
  output logic                   eFull,
  output logic                   wFull,
  output logic                   sFull,
  output logic [`FLIT_WIDTH-1:0] outFlit,
  output logic                   outValid,
  output logic [`NUM_PORTS-1:0]  outPort
);

  flitWord pushFlit [`NUM_PORTS];
  flitWord headFlit [`NUM_PORTS];
  portMask pushValid;
  portMask fullVec;
  portMask notEmpty;
  portMask pop;
  flitWord arbFlit;

  // index order is L, N, E, W, S.
  assign pushFlit[0] = lFlit;
  assign pushFlit[1] = nFlit;
  assign pushFlit[2] = eFlit;
  assign pushFlit[3] = wFlit;
  assign pushFlit[4] = sFlit;
  assign pushValid = {sValid, wValid, eValid, nValid, lValid};
  assign {sFull, wFull, eFull, nFull, lFull} = fullVec;
  assign outFlit = arbFlit;

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : genQueue
    flitQueue queue_i (
      .clk       (clk),
      .rst       (rst),
      .pushValid (pushValid[p]),
      .pushFlit  (pushFlit[p]),
      .full      (fullVec[p]),
      .pop       (pop[p]),
      .headFlit  (headFlit[p]),
      .notEmpty  (notEmpty[p])
    );
  end

  outputArbiter arbiter_i (
    .clk      (clk),
    .rst      (rst),
    .headFlit (headFlit),
    .notEmpty (notEmpty),
    .pop      (pop),
    .outFlit  (arbFlit),
    .outValid (outValid),
    .outPort  (outPort)
  );

endmodule

/* testbench/tbRouterOutputPort.sv */
`timescale 1ns/1ps
`include "router_config.svh"

module tbRouterOutputPort
  import routerPkg::*;
();

  logic clk;
  logic rst;
  flitWord inFlit [`NUM_PORTS];
  logic inValid [`NUM_PORTS];
  logic fullVec [`NUM_PORTS];
  flitWord outFlit;
  logic outValid;
  portMask outPort;

  flitWord expQ [`NUM_PORTS][$]; // flits pushed per direction and not yet seen at the output.
  flitWord expHead [`NUM_PORTS];
  logic expAvail [`NUM_PORTS];
  int expCount [`NUM_PORTS];
  flitWord expSel;
  logic selAvail;
  logic fullEarly;
  portMask rrMask;
  portMask curMask = '0;
  int remaining = 0; // bodies still owed by the packet on the output.
  int lastHead = `NUM_PORTS - 1;
  int errors = 0;
  int testErrors = 0;
  int pushed = 0;
  int checked = 0;
  int cycles = 0;
  int seed = 32'h1a01;
  logic rrActive = 1'b0;
  int lens [`NUM_PORTS][3];

  routerOutputPort dut_i (
    .clk      (clk),
    .rst      (rst),
    .lFlit    (inFlit[0]),
    .nFlit    (inFlit[1]),
    .eFlit    (inFlit[2]),
    .wFlit    (inFlit[3]),
    .sFlit    (inFlit[4]),
    .lValid   (inValid[0]),
    .nValid   (inValid[1]),
    .eValid   (inValid[2]),
    .wValid   (inValid[3]),
    .sValid   (inValid[4]),
    .lFull    (fullVec[0]),
    .nFull    (fullVec[1]),
    .eFull    (fullVec[2]),
    .wFull    (fullVec[3]),
    .sFull    (fullVec[4]),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outPort  (outPort)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic int portIndex(portMask m);
    int idx;
    idx = 0;
    for (int i = 0; i < `NUM_PORTS; i++)
      if (m[i])
        idx = i;
    return idx;
  endfunction

  function automatic int pendingFlits();
    int total;
    total = 0;
    for (int i = 0; i < `NUM_PORTS; i++)
      total = total + expQ[i].size();
    return total;
  endfunction

  function automatic int nextLength();
    int r;
    r = $random(seed) % 7;
    if (r < 0)
      r = -r;
    return r;
  endfunction

  task automatic syncHead(input int dir);
    expAvail[dir] = (expQ[dir].size() > 0);
    expHead[dir] = (expQ[dir].size() > 0) ? expQ[dir][0] : '0;
    expCount[dir] = expQ[dir].size();
  endtask

  task automatic waitCycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // called 1 ns after an edge; the flit is taken at the next edge.
  task automatic pushOne(input int dir, input flitWord f);
    while (fullVec[dir])
      waitCycles(1);
    inFlit[dir] = f;
    inValid[dir] = 1'b1;
    expQ[dir].push_back(f);
    syncHead(dir);
    pushed++;
    waitCycles(1);
    inValid[dir] = 1'b0;
  endtask

  task automatic sendPacket(input int dir, input int len,
                            input int pauseAt, input int pauseCycles);
    flitWord f;
    f = '0;
    f.headerView.flitId = headFlitId;
    f.headerView.spare = 1'b0;
    f.headerView.length = `LENGTH_WIDTH'(len);
    pushOne(dir, f);
    for (int k = 0; k < len; k++)
    begin
      if (k == pauseAt)
        waitCycles(pauseCycles); // source stalls in mid-packet.
      f = '0;
      f.bodyView.flitId = bodyFlitId;
      f.bodyView.data = (`FLIT_WIDTH - 3)'(dir * 1024 + k * 37 + len);
      pushOne(dir, f);
    end
  endtask

  task automatic streamPackets(input int dir);
    for (int k = 0; k < 3; k++)
      sendPacket(dir, lens[dir][k], -1, 0);
  endtask

  task automatic waitDrain();
    while (pendingFlits() != 0)
      waitCycles(1);
    waitCycles(3);
  endtask

  task automatic finishTest(input int num, input string name);
    $display("test %0d %s finished with %0d errors", num, name, errors - testErrors);
    testErrors = errors;
  endtask

  always_comb
  begin
    expSel = '0;
    selAvail = 1'b0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (outPort[i])
      begin
        expSel = expHead[i];
        selAvail = expAvail[i];
      end
    end
  end

  // a queue can hold no more flits than the source has pushed and not yet seen leave.
  always_comb
  begin
    fullEarly = 1'b0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (fullVec[i] && expCount[i] < `QUEUE_DEPTH)
        fullEarly = 1'b1;
    end
  end

  // next direction after lastHead that still owes flits. lastHead itself comes last.
  always_comb
  begin
    int idx;
    logic found;
    rrMask = '0;
    found = 1'b0;
    for (int k = 1; k <= `NUM_PORTS; k++)
    begin
      idx = (lastHead + k) % `NUM_PORTS;
      if (!found && expAvail[idx])
      begin
        rrMask[idx] = 1'b1;
        found = 1'b1;
      end
    end
  end

  // retire the flit that was on the output during the cycle just ended.
  always @(posedge clk)
  begin
    flitWord f;
    int idx;
    if (!rst && outValid)
    begin
      idx = portIndex(outPort);
      if (expQ[idx].size() > 0)
      begin
        f = expQ[idx].pop_front();
        syncHead(idx);
        checked++;
        if (remaining == 0)
        begin
          remaining = int'(f.headerView.length);
          curMask = portMask'(1) << idx;
          lastHead = idx;
        end
        else
          remaining--;
      end
    end
  end

  validIsExpected: assert property (@(negedge clk) disable iff (rst)
    outValid |-> ($onehot(outPort) && selAvail))
    else
    begin
      $display("error at %0t: outValid is high on port mask %b but no flit is pending there",
               $time, outPort);
      errors++;
    end

  flitMatches: assert property (@(negedge clk) disable iff (rst)
    outValid |-> (outFlit == expSel))
    else
    begin
      $display("FAIL %0t outFlit expected %h got %h", $time, expSel, outFlit);
      errors++;
    end

  packetNotSplit: assert property (@(negedge clk) disable iff (rst)
    (outValid && remaining != 0) |-> (outPort == curMask))
    else
    begin
      $display("FAIL %0t outPort expected %b got %b", $time, curMask, outPort);
      errors++;
    end

  roundRobinOrder: assert property (@(negedge clk) disable iff (rst)
    (rrActive && outValid && remaining == 0) |-> (outPort == rrMask))
    else
    begin
      $display("FAIL %0t outPort expected %b got %b", $time, rrMask, outPort);
      errors++;
    end

  fullOnlyWhenLoaded: assert property (@(negedge clk) disable iff (rst)
    !fullEarly)
    else
    begin
      $display("error at %0t: a full level is high with fewer than %0d flits outstanding",
               $time, `QUEUE_DEPTH);
      errors++;
    end

  initial
  begin
    while (cycles <= 40 * pushed + 200)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the output stopped draining after %0d cycles with %0d flits pushed",
             cycles, pushed);
    $display("Regression failed");
    $finish;
  end

  initial
  begin
    rst = 1'b1;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      inFlit[i] = '0;
      inValid[i] = 1'b0;
      syncHead(i);
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    waitCycles(20); // nothing pushed, so the output must stay quiet.
    finishTest(1, "idle after reset");

    for (int k = 0; k < 5; k++)
      sendPacket(3, nextLength(), -1, 0);
    waitDrain();
    finishTest(2, "single direction stream");

    for (int d = 0; d < `NUM_PORTS; d++)
      for (int k = 0; k < 3; k++)
        lens[d][k] = nextLength();
    fork
      streamPackets(0);
      streamPackets(1);
      streamPackets(2);
      streamPackets(3);
      streamPackets(4);
    join
    waitDrain();
    finishTest(3, "all directions without interleaving");

    rrActive = 1'b1;
    sendPacket(2, nextLength(), -1, 0); // east alone, so west is next in line.
    waitDrain();
    for (int d = 0; d < `NUM_PORTS; d++)
      lens[d][0] = nextLength();
    lens[1][0] = 0;
    fork
      sendPacket(0, lens[0][0], -1, 0);
      sendPacket(1, lens[1][0], -1, 0);
      sendPacket(2, lens[2][0], -1, 0);
      sendPacket(3, lens[3][0], -1, 0);
      sendPacket(4, lens[4][0], -1, 0);
    join
    waitDrain();
    rrActive = 1'b0;
    finishTest(4, "round robin order");

    fork
      sendPacket(0, 5, 2, 8);
      begin
        waitCycles(1);
        sendPacket(1, 3, -1, 0);
      end
    join
    waitDrain();
    finishTest(5, "grant held through a paused packet");

    $display("5 tests, %0d flits pushed, %0d flits checked, %0d errors",
             pushed, checked, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

/* sources.f */
+incdir+src
src/routerPkg.sv
src/flitQueue.sv
src/packetTimer.sv
src/outputArbiter.sv
src/routerOutputPort.sv
testbench/tbRouterOutputPort.sv

/* Makefile */
# Build and run the router output port regression with Verilator.

sim:
	verilator --binary --timing --assert -f sources.f \
		--top-module tbRouterOutputPort -Mdir obj_dir
	./obj_dir/VtbRouterOutputPort | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
